// ==== dv/l2_cache_cases.txt ====
# name port(i/d/b) op(r/w) addr(hex) data(hex) strobes(hex) refills writebacks
# Four sets of 16-byte lines, set index is address bits 5:4
rd_i_000 i r 00000000 00000000 0 1 0
rd_i_004_hit i r 00000004 00000000 0 0 0
wr_d_008 d w 00000008 deadbeef 5 0 0
rd_d_000_merged d r 00000000 00000000 0 0 0
rd_d_040 d r 00000040 00000000 0 1 0
rd_d_080_dirty_evict d r 00000080 00000000 0 1 1
rd_i_0c0_clean_evict i r 000000c0 00000000 0 1 0
rd_d_000_again d r 00000000 00000000 0 1 0
both_110 b w 00000110 12345678 f 1 0
wr_d_114 d w 00000114 aaaa5555 3 0 0
rd_d_150 d r 00000150 00000000 0 1 0
rd_i_190_dirty_evict i r 00000190 00000000 0 1 1
rd_d_154_hit d r 00000154 00000000 0 0 0
rd_i_110_refetch i r 00000110 00000000 0 1 0
wr_d_ffc d w 00000ffc 0badf00d 8 1 0
rd_d_ff0_hit d r 00000ff0 00000000 0 0 0
both_ff4_read b r 00000ff4 00000000 0 0 0

// ==== tb.f ====
rtl/l2_geom_pkg.sv
rtl/l2_ctrl_pkg.sv
rtl/l2_req_arbiter.sv
rtl/l2_tag_store.sv
rtl/l2_data_store.sv
rtl/l2_ctrl_fsm.sv
rtl/l2_cache_top.sv
dv/l2_clk_gen.sv
dv/l2_cache_checker.sv
dv/l2_cache_asserts.sv
dv/l2_cache_tb.sv

// ==== Makefile ====
SRCS := $(shell cat tb.f)

obj_dir/Vl2_cache_tb: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module l2_cache_tb -f tb.f

.PHONY: run clean

run: obj_dir/Vl2_cache_tb
	./obj_dir/Vl2_cache_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== dv/l2_cache_tb.sv ====
`timescale 1ns/100ps

module l2_cache_tb;

    localparam int timeout_cycles = 300;

    logic clk;
    logic reset;

    logic                i_req = 1'b0;
    l2_geom_pkg::addr_t  i_addr = '0;
    logic                d_req = 1'b0;
    logic                d_wr = 1'b0;
    l2_geom_pkg::addr_t  d_addr = '0;
    l2_geom_pkg::word_t  d_wdata = '0;
    l2_geom_pkg::wstrb_t d_wstrb = '0;
    logic                mem_addr_ok_r = 1'b0;
    logic                mem_addr_ok_w = 1'b0;
    logic                mem_data_ok = 1'b0;
    l2_geom_pkg::line_t  mem_rline = '0;

    logic               i_addr_ok;
    logic               i_data_ok;
    l2_geom_pkg::line_t i_rdata;
    logic               d_addr_ok;
    logic               d_data_ok;
    l2_geom_pkg::line_t d_rdata;
    logic               mem_req_r;
    l2_geom_pkg::addr_t mem_addr_r;
    logic               mem_req_w;
    l2_geom_pkg::addr_t mem_addr_w;
    l2_geom_pkg::line_t mem_wline;
    logic               mem_rdy;

    logic [255:0] case_name = '0;
    logic [3:0]   exp_rd = '0;
    logic [3:0]   exp_wb = '0;
    logic         case_end = 1'b0;
    logic         timed_out = 1'b0;
    int           errors;
    int           cases_passed;
    int           cases_failed;

    l2_geom_pkg::word_t mem [0:1023];
    l2_geom_pkg::addr_t rd_addr = '0;
    int                 wr_wait = 0;
    int                 rd_wait = 0;
    int                 data_wait = 0;

    l2_clk_gen u_l2_clk_gen (
        .clk  (clk),
        .reset(reset)
    );

    l2_cache_top #(
        .index_width(2)
    ) u_l2_cache_top (.*);

    l2_cache_checker u_l2_cache_checker (.*);

    // 4 KB memory, fixed latencies on every channel
    initial begin
        for (int k = 0; k < 1024; k++) begin
            mem[k] = (k * 4) ^ 32'hc3a5_0f1e;
        end
    end

    always @(posedge clk) begin
        mem_addr_ok_w <= 1'b0;
        mem_addr_ok_r <= 1'b0;
        mem_data_ok <= 1'b0;
        if (mem_req_w && !mem_addr_ok_w) begin
            wr_wait <= wr_wait + 1;
            if (wr_wait == 2) begin
                mem_addr_ok_w <= 1'b1;
                wr_wait <= 0;
                for (int w = 0; w < 4; w++) begin
                    mem[{mem_addr_w[11:4], w[1:0]}] <= mem_wline[w*32 +: 32];
                end
            end
        end
        if (mem_req_r && !mem_addr_ok_r) begin
            rd_wait <= rd_wait + 1;
            if (rd_wait == 2) begin
                mem_addr_ok_r <= 1'b1;
                rd_addr <= mem_addr_r;
                rd_wait <= 0;
            end
        end
        if (mem_rdy && !mem_data_ok) begin
            data_wait <= data_wait + 1;
            if (data_wait == 3) begin
                mem_data_ok <= 1'b1;
                mem_rline <= {mem[{rd_addr[11:4], 2'd3}], mem[{rd_addr[11:4], 2'd2}],
                              mem[{rd_addr[11:4], 2'd1}], mem[{rd_addr[11:4], 2'd0}]};
                data_wait <= 0;
            end
        end
    end

    task automatic issue_i(input l2_geom_pkg::addr_t a);
        int n;
        @(posedge clk);
        i_req <= 1'b1;
        i_addr <= a;
        n = 0;
        @(negedge clk);
        while (!i_addr_ok && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        i_req <= 1'b0;
        if (n >= timeout_cycles) begin
            $display("Timeout in %0s: i_addr_ok never came", case_name);
            timed_out = 1'b1;
            return;
        end
        n = 0;
        @(negedge clk);
        while (!i_data_ok && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (n >= timeout_cycles) begin
            $display("Timeout in %0s: i_data_ok never came", case_name);
            timed_out = 1'b1;
        end
    endtask

    task automatic issue_d(input logic wr, input l2_geom_pkg::addr_t a,
                           input l2_geom_pkg::word_t data, input l2_geom_pkg::wstrb_t strb);
        int n;
        @(posedge clk);
        d_req <= 1'b1;
        d_wr <= wr;
        d_addr <= a;
        d_wdata <= data;
        d_wstrb <= strb;
        n = 0;
        @(negedge clk);
        while (!d_addr_ok && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        d_req <= 1'b0;
        if (n >= timeout_cycles) begin
            $display("Timeout in %0s: d_addr_ok never came", case_name);
            timed_out = 1'b1;
            return;
        end
        n = 0;
        @(negedge clk);
        while (!d_data_ok && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (n >= timeout_cycles) begin
            $display("Timeout in %0s: d_data_ok never came", case_name);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int                  fd;
        int                  n;
        string               line_s;
        logic [255:0]        name_f;
        logic [7:0]          port_f;
        logic [7:0]          op_f;
        l2_geom_pkg::addr_t  addr_f;
        l2_geom_pkg::word_t  data_f;
        l2_geom_pkg::wstrb_t strb_f;
        logic [3:0]          rd_f;
        logic [3:0]          wb_f;

        fd = $fopen("dv/l2_cache_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            timed_out = 1'b1;
        end
        n = 0;
        @(posedge clk);
        while (reset && n < 20) begin
            @(posedge clk);
            n++;
        end
        @(posedge clk);

        while (fd != 0 && !timed_out && $fgets(line_s, fd) != 0) begin
            if (line_s.len() < 2 || line_s.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line_s, "%s %s %s %h %h %h %d %d", name_f, port_f, op_f,
                        addr_f, data_f, strb_f, rd_f, wb_f);
            if (n != 8) begin
                continue;
            end
            @(posedge clk);
            case_name <= name_f;
            exp_rd <= rd_f;
            exp_wb <= wb_f;
            // Port b raises both requests on the same edge
            if (port_f == "b") begin
                fork
                    issue_d(op_f == "w", addr_f, data_f, strb_f);
                    issue_i(addr_f);
                join
            end else if (port_f == "i") begin
                issue_i(addr_f);
            end else begin
                issue_d(op_f == "w", addr_f, data_f, strb_f);
            end
            @(posedge clk);
            case_end <= 1'b1;
            @(posedge clk);
            case_end <= 1'b0;
        end

        repeat (2) @(posedge clk);
        $display("Cases passed %0d, failed %0d, errors %0d",
                 cases_passed, cases_failed, errors);
        if (timed_out || errors != 0 || cases_passed == 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

// ==== dv/l2_cache_asserts.sv ====
`timescale 1ns/100ps

module l2_cache_asserts (
    input logic clk,
    input logic reset,
    input logic i_addr_ok,
    input logic d_addr_ok,
    input logic mem_req_r,
    input logic mem_req_w,
    input logic mem_rdy,
    input logic mem_addr_ok_r
);

    a_addr_ok_pulse: assert property (@(posedge clk) disable iff (reset)
        (i_addr_ok || d_addr_ok) |=> !(i_addr_ok || d_addr_ok))
        else $error("addr_ok held for more than one cycle");

    a_single_grant: assert property (@(posedge clk) disable iff (reset)
        !(i_addr_ok && d_addr_ok))
        else $error("i_addr_ok and d_addr_ok high together");

    a_mem_req_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_req_r && mem_req_w))
        else $error("mem_req_r and mem_req_w high together");

    // mem_rdy may only open after an accepted refill address
    a_rdy_after_addr: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_rdy) |-> $past(mem_addr_ok_r))
        else $error("mem_rdy rose without a preceding mem_addr_ok_r");

endmodule

bind l2_cache_top l2_cache_asserts u_l2_cache_asserts (.*);

// ==== dv/l2_cache_checker.sv ====
`timescale 1ns/100ps

module l2_cache_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic [255:0]        case_name,
    input  logic [3:0]          exp_rd,
    input  logic [3:0]          exp_wb,
    input  logic                case_end,
    input  l2_geom_pkg::addr_t  i_addr,
    input  logic                i_addr_ok,
    input  logic                i_data_ok,
    input  l2_geom_pkg::line_t  i_rdata,
    input  logic                d_req,
    input  logic                d_wr,
    input  l2_geom_pkg::addr_t  d_addr,
    input  l2_geom_pkg::word_t  d_wdata,
    input  l2_geom_pkg::wstrb_t d_wstrb,
    input  logic                d_addr_ok,
    input  logic                d_data_ok,
    input  l2_geom_pkg::line_t  d_rdata,
    input  logic                mem_req_r,
    input  logic                mem_addr_ok_r,
    input  logic                mem_req_w,
    input  l2_geom_pkg::addr_t  mem_addr_w,
    input  l2_geom_pkg::line_t  mem_wline,
    input  logic                mem_addr_ok_w,
    input  logic                mem_rdy,
    output int                  errors,
    output int                  cases_passed,
    output int                  cases_failed
);

    l2_geom_pkg::word_t image [0:1023];
    l2_geom_pkg::addr_t acc_addr;
    l2_geom_pkg::line_t got_line;
    logic busy;
    logic acc_wr;
    logic reset_d;
    int   cycle;
    int   acc_cycle;
    int   case_errs;
    int   rd_count;
    int   wb_count;

    // Same fill rule as the memory model
    initial begin
        for (int k = 0; k < 1024; k++) begin
            image[k] = (k * 4) ^ 32'hc3a5_0f1e;
        end
        busy = 1'b0;
        reset_d = 1'b0;
        cycle = 0;
        case_errs = 0;
        rd_count = 0;
        wb_count = 0;
        errors = 0;
        cases_passed = 0;
        cases_failed = 0;
    end

    function automatic l2_geom_pkg::line_t image_line(input l2_geom_pkg::addr_t a);
        return {image[{a[11:4], 2'd3}], image[{a[11:4], 2'd2}],
                image[{a[11:4], 2'd1}], image[{a[11:4], 2'd0}]};
    endfunction

    task automatic count_failure();
        case_errs++;
        errors++;
    endtask

    always @(posedge clk) begin
        cycle++;
        // Quiet outputs through reset and the first cycle after
        if ((reset && reset_d) || (!reset && reset_d)) begin
            if (i_addr_ok || i_data_ok || d_addr_ok || d_data_ok ||
                mem_req_r || mem_req_w || mem_rdy) begin
                $display("Response or memory request output high around reset");
                count_failure();
            end
        end
        reset_d <= reset;

        if (!reset) begin
            if (i_addr_ok && d_req) begin
                $display("%0s: instruction request granted over a waiting data request",
                         case_name);
                count_failure();
            end
            if ((i_addr_ok || d_addr_ok) && busy) begin
                $display("%0s: request accepted while another was in flight", case_name);
                count_failure();
            end
            if (d_addr_ok) begin
                busy = 1'b1;
                acc_addr = d_addr;
                acc_wr = d_wr;
                acc_cycle = cycle;
                if (d_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (d_wstrb[b]) begin
                            image[d_addr[11:2]][b*8 +: 8] = d_wdata[b*8 +: 8];
                        end
                    end
                end
            end else if (i_addr_ok) begin
                busy = 1'b1;
                acc_addr = i_addr;
                acc_wr = 1'b0;
                acc_cycle = cycle;
            end

            if (mem_req_r && mem_addr_ok_r) begin
                rd_count++;
            end
            if (mem_req_r && exp_rd == 4'd0) begin
                $display("%0s: memory read raised on an access expected to hit", case_name);
                count_failure();
            end
            if (mem_req_w && mem_addr_ok_w) begin
                wb_count++;
                if (mem_wline !== image_line(mem_addr_w)) begin
                    $display("Fail %0s: writeback line at %h expected %h actual %h",
                             case_name, mem_addr_w, image_line(mem_addr_w), mem_wline);
                    count_failure();
                end
            end

            if (i_data_ok || d_data_ok) begin
                if (!busy) begin
                    $display("%0s: data_ok with no request in flight", case_name);
                    count_failure();
                end else begin
                    got_line = i_data_ok ? i_rdata : d_rdata;
                    if (!acc_wr && got_line !== image_line(acc_addr)) begin
                        $display("Fail %0s: line at %h expected %h actual %h",
                                 case_name, acc_addr, image_line(acc_addr), got_line);
                        count_failure();
                    end
                    if (exp_rd == 4'd0 && cycle - acc_cycle != 1) begin
                        $display("%0s: hit took %0d cycles from addr_ok to data_ok",
                                 case_name, cycle - acc_cycle);
                        count_failure();
                    end
                    busy = 1'b0;
                end
            end

            if (case_end) begin
                if (rd_count != int'(exp_rd)) begin
                    $display("Fail %0s: refills expected %0d actual %0d",
                             case_name, exp_rd, rd_count);
                    count_failure();
                end
                if (wb_count != int'(exp_wb)) begin
                    $display("Fail %0s: writebacks expected %0d actual %0d",
                             case_name, exp_wb, wb_count);
                    count_failure();
                end
                if (case_errs == 0) begin
                    $display("Case %0s ok", case_name);
                    cases_passed++;
                end else begin
                    $display("Case %0s failed with %0d errors", case_name, case_errs);
                    cases_failed++;
                end
                case_errs = 0;
                rd_count = 0;
                wb_count = 0;
            end
        end
    end

endmodule

// ==== dv/l2_clk_gen.sv ====
`timescale 1ns/100ps

module l2_clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== rtl/l2_cache_top.sv ====
`timescale 1ns/100ps

module l2_cache_top #(
    parameter int index_width = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_req,
    input  l2_geom_pkg::addr_t  i_addr,
    output logic                i_addr_ok,
    output logic                i_data_ok,
    output l2_geom_pkg::line_t  i_rdata,
    input  logic                d_req,
    input  logic                d_wr,
    input  l2_geom_pkg::addr_t  d_addr,
    input  l2_geom_pkg::word_t  d_wdata,
    input  l2_geom_pkg::wstrb_t d_wstrb,
    output logic                d_addr_ok,
    output logic                d_data_ok,
    output l2_geom_pkg::line_t  d_rdata,
    output logic                mem_req_r,
    output l2_geom_pkg::addr_t  mem_addr_r,
    input  logic                mem_addr_ok_r,
    output logic                mem_req_w,
    output l2_geom_pkg::addr_t  mem_addr_w,
    output l2_geom_pkg::line_t  mem_wline,
    input  logic                mem_addr_ok_w,
    output logic                mem_rdy,
    input  logic                mem_data_ok,
    input  l2_geom_pkg::line_t  mem_rline
);

    localparam int tag_width = 28 - index_width;
    localparam int low_bits = l2_geom_pkg::offset_width + 2;

    l2_ctrl_pkg::req_src_t                src;
    l2_ctrl_pkg::req_src_t                buf_src;
    l2_geom_pkg::addr_t                   buf_addr;
    logic [index_width-1:0]               buf_index;
    logic [tag_width-1:0]                 buf_tag;
    logic [l2_geom_pkg::offset_width-1:0] buf_offset;
    l2_geom_pkg::word_t                   buf_wdata;
    l2_geom_pkg::wstrb_t                  buf_wstrb;

    logic capture;
    logic tag_we;
    logic fill_way;
    logic set_dirty;
    logic lru_touch;
    logic touch_way;
    logic line_we;
    logic word_we;
    logic resp_way;

    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    logic                 victim_valid;
    logic                 victim_dirty;
    logic [tag_width-1:0] victim_tag;

    l2_geom_pkg::line_t line0;
    l2_geom_pkg::line_t line1;
    l2_geom_pkg::line_t resp_line;
    l2_geom_pkg::line_t refill_line;

    l2_req_arbiter #(
        .index_width(index_width)
    ) u_l2_req_arbiter (
        .clk       (clk),
        .reset     (reset),
        .capture   (capture),
        .i_req     (i_req),
        .i_addr    (i_addr),
        .d_req     (d_req),
        .d_wr      (d_wr),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_wstrb   (d_wstrb),
        .src       (src),
        .buf_src   (buf_src),
        .buf_addr  (buf_addr),
        .buf_index (buf_index),
        .buf_tag   (buf_tag),
        .buf_offset(buf_offset),
        .buf_wdata (buf_wdata),
        .buf_wstrb (buf_wstrb)
    );

    l2_tag_store #(
        .index_width(index_width)
    ) u_l2_tag_store (
        .clk         (clk),
        .reset       (reset),
        .index       (buf_index),
        .tag         (buf_tag),
        .tag_we      (tag_we),
        .fill_way    (fill_way),
        .set_dirty   (set_dirty),
        .dirty_way   (touch_way),
        .lru_touch   (lru_touch),
        .touch_way   (touch_way),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_valid(victim_valid),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    l2_data_store #(
        .index_width(index_width)
    ) u_l2_data_store (
        .clk      (clk),
        .index    (buf_index),
        .offset   (buf_offset),
        .way_sel  (fill_way),
        .line_we  (line_we),
        .word_we  (word_we),
        .fill_line(refill_line),
        .wdata    (buf_wdata),
        .wstrb    (buf_wstrb),
        .line0    (line0),
        .line1    (line1)
    );

    l2_ctrl_fsm u_l2_ctrl_fsm (
        .clk          (clk),
        .reset        (reset),
        .src          (src),
        .buf_src      (buf_src),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .mem_addr_ok_r(mem_addr_ok_r),
        .mem_addr_ok_w(mem_addr_ok_w),
        .mem_data_ok  (mem_data_ok),
        .capture      (capture),
        .i_addr_ok    (i_addr_ok),
        .d_addr_ok    (d_addr_ok),
        .i_data_ok    (i_data_ok),
        .d_data_ok    (d_data_ok),
        .mem_req_r    (mem_req_r),
        .mem_req_w    (mem_req_w),
        .mem_rdy      (mem_rdy),
        .tag_we       (tag_we),
        .fill_way     (fill_way),
        .set_dirty    (set_dirty),
        .lru_touch    (lru_touch),
        .touch_way    (touch_way),
        .line_we      (line_we),
        .word_we      (word_we),
        .resp_way     (resp_way)
    );

    assign resp_line = resp_way ? line1 : line0;
    assign i_rdata   = resp_line;
    assign d_rdata   = resp_line;

    // Refill data only lasts for the mem_data_ok cycle
    always_ff @(posedge clk) begin
        if (mem_rdy && mem_data_ok) begin
            refill_line <= mem_rline;
        end
    end

    assign mem_addr_r = {buf_addr[31:low_bits], {low_bits{1'b0}}};
    assign mem_addr_w = {victim_tag, buf_index, {low_bits{1'b0}}};
    assign mem_wline  = victim_way ? line1 : line0;

endmodule

// ==== rtl/l2_ctrl_fsm.sv ====
`timescale 1ns/100ps

module l2_ctrl_fsm (
    input  logic                  clk,
    input  logic                  reset,
    input  l2_ctrl_pkg::req_src_t src,
    input  l2_ctrl_pkg::req_src_t buf_src,
    input  logic                  hit,
    input  logic                  hit_way,
    input  logic                  victim_way,
    input  logic                  victim_valid,
    input  logic                  victim_dirty,
    input  logic                  mem_addr_ok_r,
    input  logic                  mem_addr_ok_w,
    input  logic                  mem_data_ok,
    output logic                  capture,
    output logic                  i_addr_ok,
    output logic                  d_addr_ok,
    output logic                  i_data_ok,
    output logic                  d_data_ok,
    output logic                  mem_req_r,
    output logic                  mem_req_w,
    output logic                  mem_rdy,
    output logic                  tag_we,
    output logic                  fill_way,
    output logic                  set_dirty,
    output logic                  lru_touch,
    output logic                  touch_way,
    output logic                  line_we,
    output logic                  word_we,
    output logic                  resp_way
);

    l2_ctrl_pkg::ctrl_state_t state;
    l2_ctrl_pkg::ctrl_state_t state_next;

    logic done;
    logic buf_is_icache;
    logic buf_is_write;

    assign buf_is_icache = (buf_src == l2_ctrl_pkg::src_icache);
    assign buf_is_write  = (buf_src == l2_ctrl_pkg::src_dwrite);

    // Acceptance happens only from idle, one request in flight
    assign capture   = (state == l2_ctrl_pkg::st_idle) && (src != l2_ctrl_pkg::src_none);
    assign i_addr_ok = capture && (src == l2_ctrl_pkg::src_icache);
    assign d_addr_ok = capture && (src != l2_ctrl_pkg::src_icache);

    assign done      = (state == l2_ctrl_pkg::st_lookup) && hit;
    assign i_data_ok = done && buf_is_icache;
    assign d_data_ok = done && !buf_is_icache;

    assign lru_touch = done;
    assign touch_way = hit_way;
    assign word_we   = done && buf_is_write;
    assign set_dirty = done && buf_is_write;
    assign resp_way  = hit_way;

    assign mem_req_w = (state == l2_ctrl_pkg::st_writeback);
    assign mem_req_r = (state == l2_ctrl_pkg::st_refill_req);
    assign mem_rdy   = (state == l2_ctrl_pkg::st_refill_wait);

    assign line_we  = (state == l2_ctrl_pkg::st_refill_fill);
    assign tag_we   = line_we;
    // Refill goes to the victim, word writes to the hit way
    assign fill_way = line_we ? victim_way : hit_way;

    always_comb begin
        state_next = state;
        case (state)
            l2_ctrl_pkg::st_idle: begin
                if (capture) begin
                    state_next = l2_ctrl_pkg::st_lookup;
                end
            end
            l2_ctrl_pkg::st_lookup: begin
                if (hit) begin
                    state_next = l2_ctrl_pkg::st_idle;
                end else if (victim_valid && victim_dirty) begin
                    state_next = l2_ctrl_pkg::st_writeback;
                end else begin
                    state_next = l2_ctrl_pkg::st_refill_req;
                end
            end
            l2_ctrl_pkg::st_writeback: begin
                if (mem_addr_ok_w) begin
                    state_next = l2_ctrl_pkg::st_refill_req;
                end
            end
            l2_ctrl_pkg::st_refill_req: begin
                if (mem_addr_ok_r) begin
                    state_next = l2_ctrl_pkg::st_refill_wait;
                end
            end
            l2_ctrl_pkg::st_refill_wait: begin
                if (mem_data_ok) begin
                    state_next = l2_ctrl_pkg::st_refill_fill;
                end
            end
            l2_ctrl_pkg::st_refill_fill: begin
                state_next = l2_ctrl_pkg::st_lookup;
            end
            default: begin
                state_next = l2_ctrl_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= l2_ctrl_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== rtl/l2_data_store.sv ====
`timescale 1ns/100ps

module l2_data_store #(
    parameter int index_width = 2
) (
    input  logic                                 clk,
    input  logic [index_width-1:0]               index,
    input  logic [l2_geom_pkg::offset_width-1:0] offset,
    input  logic                                 way_sel,
    input  logic                                 line_we,
    input  logic                                 word_we,
    input  l2_geom_pkg::line_t                   fill_line,
    input  l2_geom_pkg::word_t                   wdata,
    input  l2_geom_pkg::wstrb_t                  wstrb,
    output l2_geom_pkg::line_t                   line0,
    output l2_geom_pkg::line_t                   line1
);

    localparam int sets = 1 << index_width;
    localparam int lanes = $bits(l2_geom_pkg::wstrb_t);

    l2_geom_pkg::line_t way_lines [0:1][0:sets-1];
    l2_geom_pkg::line_t merged_line;

    assign line0 = way_lines[0][index];
    assign line1 = way_lines[1][index];

    // Strobed bytes replace their lanes in the addressed word only
    always_comb begin
        merged_line = way_sel ? line1 : line0;
        for (int w = 0; w < l2_geom_pkg::line_words; w++) begin
            for (int b = 0; b < lanes; b++) begin
                if (w == int'(offset) && wstrb[b]) begin
                    merged_line[w*32 + b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            way_lines[way_sel][index] <= fill_line;
        end else if (word_we) begin
            way_lines[way_sel][index] <= merged_line;
        end
    end

endmodule

// ==== rtl/l2_tag_store.sv ====
`timescale 1ns/100ps

module l2_tag_store #(
    parameter int index_width = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [index_width-1:0]  index,
    input  logic [27-index_width:0] tag,
    input  logic                    tag_we,
    input  logic                    fill_way,
    input  logic                    set_dirty,
    input  logic                    dirty_way,
    input  logic                    lru_touch,
    input  logic                    touch_way,
    output logic                    hit,
    output logic                    hit_way,
    output logic                    victim_way,
    output logic                    victim_valid,
    output logic                    victim_dirty,
    output logic [27-index_width:0] victim_tag
);

    localparam int tag_width = 28 - index_width;
    localparam int sets = 1 << index_width;

    logic [tag_width-1:0] tags [0:1][0:sets-1];
    logic [1:0][sets-1:0] valid;
    logic [1:0][sets-1:0] dirty;
    // Set bit names the least recently used way
    logic [sets-1:0]      lru;

    logic hit0;
    logic hit1;

    assign hit0 = valid[0][index] && (tags[0][index] == tag);
    assign hit1 = valid[1][index] && (tags[1][index] == tag);

    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    // Empty ways are filled before anything is evicted
    always_comb begin
        if (!valid[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[index];
        end
    end

    assign victim_valid = valid[victim_way][index];
    assign victim_dirty = valid[victim_way][index] && dirty[victim_way][index];
    assign victim_tag   = tags[victim_way][index];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (tag_we) begin
                valid[fill_way][index] <= 1'b1;
                dirty[fill_way][index] <= 1'b0;
            end else if (set_dirty) begin
                dirty[dirty_way][index] <= 1'b1;
            end
            if (lru_touch) begin
                lru[index] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[fill_way][index] <= tag;
        end
    end

endmodule

// ==== rtl/l2_req_arbiter.sv ====
`timescale 1ns/100ps

module l2_req_arbiter #(
    parameter int index_width = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  capture,
    input  logic                                  i_req,
    input  l2_geom_pkg::addr_t                    i_addr,
    input  logic                                  d_req,
    input  logic                                  d_wr,
    input  l2_geom_pkg::addr_t                    d_addr,
    input  l2_geom_pkg::word_t                    d_wdata,
    input  l2_geom_pkg::wstrb_t                   d_wstrb,
    output l2_ctrl_pkg::req_src_t                 src,
    output l2_ctrl_pkg::req_src_t                 buf_src,
    output l2_geom_pkg::addr_t                    buf_addr,
    output logic [index_width-1:0]                buf_index,
    output logic [27-index_width:0]               buf_tag,
    output logic [l2_geom_pkg::offset_width-1:0]  buf_offset,
    output l2_geom_pkg::word_t                    buf_wdata,
    output l2_geom_pkg::wstrb_t                   buf_wstrb
);

    localparam int low_bits = l2_geom_pkg::offset_width + 2;

    l2_geom_pkg::addr_t sel_addr;

    // Data port always wins
    always_comb begin
        if (d_req) begin
            src = d_wr ? l2_ctrl_pkg::src_dwrite : l2_ctrl_pkg::src_dread;
        end else if (i_req) begin
            src = l2_ctrl_pkg::src_icache;
        end else begin
            src = l2_ctrl_pkg::src_none;
        end
    end

    assign sel_addr = d_req ? d_addr : i_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_src <= l2_ctrl_pkg::src_none;
        end else if (capture) begin
            buf_src <= src;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_addr  <= sel_addr;
            buf_wdata <= d_wdata;
            buf_wstrb <= d_wstrb;
        end
    end

    assign buf_offset = buf_addr[low_bits-1:2];
    assign buf_index  = buf_addr[low_bits+index_width-1:low_bits];
    assign buf_tag    = buf_addr[31:low_bits+index_width];

endmodule

// ==== rtl/l2_ctrl_pkg.sv ====
package l2_ctrl_pkg;

    // Who owns a request, data reads and writes kept apart
    typedef enum logic [1:0] {
        src_none,
        src_icache,
        src_dread,
        src_dwrite
    } req_src_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill_req,
        st_refill_wait,
        st_refill_fill
    } ctrl_state_t;

endpackage

// ==== rtl/l2_geom_pkg.sv ====
package l2_geom_pkg;

    // Byte address as seen by both requesters and the memory bridge
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;

    // One strobe bit per byte lane of a word
    typedef logic [3:0] wstrb_t;

    // Word k of a line sits at bits [32k+31:32k]
    typedef logic [127:0] line_t;

    // Word offset bits inside a line
    localparam int offset_width = 2;

    localparam int line_words = 4;

endpackage
